// ==== sources.f ====
+incdir+rtl
rtl/icache_pkg.sv
rtl/fill_if.sv
rtl/icache_ctrl.sv
rtl/refill_counter.sv
rtl/icache_tag_array.sv
rtl/icache_data_array.sv
rtl/icache_top.sv
verif/burst_mem_model.sv
verif/icache_tb.sv

// ==== Bender.yml ====
package:
  name: icache

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/icache_pkg.sv
      - rtl/fill_if.sv
      - rtl/icache_ctrl.sv
      - rtl/refill_counter.sv
      - rtl/icache_tag_array.sv
      - rtl/icache_data_array.sv
      - rtl/icache_top.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - verif/burst_mem_model.sv
      - verif/icache_tb.sv

// ==== verif/icache_tb.sv ====
`timescale 1ns/1ps
`include "icache_params.svh"

module icache_tb;

    localparam int lines     = 1 << `ICACHE_INDEX_BITS;
    localparam int tag_shift = `ICACHE_INDEX_BITS + `ICACHE_OFFSET_BITS;
    localparam int timeout   = 400;     // cycles per fetch
    localparam int err_burst = 4;

    logic              clock;
    logic              reset;
    icache_pkg::addr_t fetch_addr;
    logic              fetch_valid;
    logic              fetch_ready;
    icache_pkg::word_t fetch_data;
    logic              mem_valid;
    icache_pkg::addr_t mem_addr;
    logic              mem_ready;
    icache_pkg::word_t mem_data;
    logic              mem_err;
    int                burst_count;

    int          seed       = 32'hf2db;
    int          mismatches = 0;
    int          failures   = 0;
    bit          stop       = 1'b0;     // set on a timeout
    bit          ref_valid [lines];     // reference tag/valid copy
    logic [31:0] ref_tag   [lines];

    icache_top dut (
        .clock       (clock),
        .reset       (reset),
        .fetch_addr  (fetch_addr),
        .fetch_valid (fetch_valid),
        .fetch_ready (fetch_ready),
        .fetch_data  (fetch_data),
        .mem_valid   (mem_valid),
        .mem_addr    (mem_addr),
        .mem_ready   (mem_ready),
        .mem_data    (mem_data),
        .mem_err     (mem_err)
    );

    burst_mem_model u_mem (
        .clock       (clock),
        .reset       (reset),
        .mem_valid   (mem_valid),
        .mem_addr    (mem_addr),
        .err_burst   (err_burst),
        .mem_ready   (mem_ready),
        .mem_data    (mem_data),
        .mem_err     (mem_err),
        .burst_count (burst_count)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    task automatic compare_word(input string name, input logic [31:0] got,
                                input logic [31:0] expected);
        assert (got === expected) else begin
            mismatches++;
            $display("MISMATCH %s: got %h expected %h", name, got, expected);
        end
    endtask

    task automatic expect_true(input bit cond, input string what);
        assert (cond) else begin
            failures++;
            $display("check failed: %s", what);
        end
    endtask

    // ------------------------------
    // one fetch, checked against the reference
    // ------------------------------
    task automatic fetch(input icache_pkg::addr_t addr);
        int          index;
        logic [31:0] tag;
        bit          predict_hit;
        int          bursts_before;
        int          bursts_after;
        int          expect_bursts;
        int          n;
        int          beats;
        int          last_beat_n;
        int          ready_n;
        bit          saw_burst;
        if (!stop) begin
            index         = (addr >> `ICACHE_OFFSET_BITS) % lines;
            tag           = addr >> tag_shift;
            predict_hit   = ref_valid[index] && (ref_tag[index] == tag);
            n             = 0;
            beats         = 0;
            last_beat_n   = -100;
            ready_n       = 0;
            saw_burst     = 1'b0;
            bursts_after  = 0;
            expect_bursts = 0;
            @(posedge clock);
            #1;
            bursts_before = burst_count;
            fetch_addr    = addr;
            fetch_valid   = 1'b1;
            while (ready_n == 0 && n < timeout) begin
                @(negedge clock);
                n++;
                if (mem_valid) begin
                    saw_burst = 1'b1;
                    compare_word("mem_addr", mem_addr,
                                 addr & ~((32'h1 << `ICACHE_OFFSET_BITS) - 1));
                    if (mem_err) begin
                        beats = 0;              // burst abandoned
                    end else if (mem_ready) begin
                        beats++;
                        if (beats == `ICACHE_WORDS_PER_LINE) begin
                            last_beat_n = n;
                            beats       = 0;
                        end
                    end
                end
                if (fetch_ready) begin
                    expect_true(!mem_valid, "fetch_ready while a burst is running");
                    ready_n      = n;
                    bursts_after = burst_count;
                end
            end
            if (ready_n == 0) begin
                $display("timeout: no fetch_ready for address %h within %0d cycles",
                         addr, timeout);
                failures++;
                stop = 1'b1;
            end else begin
                compare_word("fetch_data", fetch_data, {addr[31:2], 2'b00} ^ 32'h5a5a_0000);
                if (predict_hit) begin
                    expect_true(!saw_burst, "burst started on a predicted hit");
                    expect_true(ready_n == 2, $sformatf(
                        "hit answered %0d cycles after valid, expected 1", ready_n - 1));
                end else begin
                    // error burst plus its retry
                    expect_bursts = (bursts_before + 1 == err_burst) ? 2 : 1;
                    expect_true(saw_burst, "no burst on a predicted miss");
                    expect_true(ready_n == last_beat_n + 2, $sformatf(
                        "fetch_ready %0d cycles after the last beat, expected 2",
                        ready_n - last_beat_n));
                end
                compare_word("burst_count", bursts_after, bursts_before + expect_bursts);
                ref_valid[index] = 1'b1;
                ref_tag[index]   = tag;
                @(posedge clock);
                #1;
                fetch_valid = 1'b0;
            end
        end
    endtask

    task automatic finish_run();
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    endtask

    initial begin
        int                i;
        icache_pkg::addr_t addr;
        fetch_addr  = '0;
        fetch_valid = 1'b0;
        reset       = 1'b1;
        repeat (3) @(posedge clock);
        #1;
        reset = 1'b0;
        @(negedge clock);
        expect_true(!fetch_ready && !mem_valid, "fetch_ready or mem_valid high after reset");

        // ------------------------------
        // directed
        // ------------------------------
        fetch(32'h0000_1000);   // cold miss
        fetch(32'h0000_1004);   // other word, hit
        fetch(32'h0000_1000);
        fetch(32'h0000_2000);   // same index, new tag
        fetch(32'h0000_1000);   // evicted, misses again
        fetch(32'h0000_0048);   // burst 4 gets the error
        fetch(32'h0000_004c);

        // random mix, 4 tags over all lines
        for (i = 0; i < 40; i++) begin
            addr = (($random(seed) & 32'h3) << 12) | ($random(seed) & 32'h7c);
            fetch(addr);
        end
        finish_run();
    end

endmodule

// ==== verif/burst_mem_model.sv ====
`timescale 1ns/1ps
`include "icache_params.svh"

module burst_mem_model (
    input  logic              clock,
    input  logic              reset,
    input  logic              mem_valid,
    input  icache_pkg::addr_t mem_addr,
    input  int                err_burst,    // burst number that sees the error
    output logic              mem_ready,
    output icache_pkg::word_t mem_data,
    output logic              mem_err,
    output int                burst_count
);

    int seed = 32'hf2db;
    int beat;               // beats taken in the current burst
    bit prev_valid;
    bit err_done;           // only one error per run

    initial begin
        mem_ready   = 1'b0;
        mem_err     = 1'b0;
        mem_data    = '0;
        burst_count = 0;
        beat        = 0;
        prev_valid  = 1'b0;
        err_done    = 1'b0;
    end

    // ------------------------------
    // responder, 1 ns after each edge
    // ------------------------------
    always @(posedge clock) begin
        #1;
        if (reset) begin
            mem_ready   = 1'b0;
            mem_err     = 1'b0;
            burst_count = 0;
            beat        = 0;
            prev_valid  = 1'b0;
        end else begin
            if (mem_ready) begin
                beat++;                             // taken at this edge
            end
            if (mem_valid && !prev_valid) begin
                burst_count++;                      // new burst
                beat = 0;
            end
            prev_valid = mem_valid;
            mem_ready  = 1'b0;
            mem_err    = 1'b0;
            mem_data   = (mem_addr + 32'(beat * 4)) ^ 32'h5a5a_0000;
            if (mem_valid && beat < `ICACHE_WORDS_PER_LINE) begin
                if (burst_count == err_burst && beat == 1 && !err_done) begin
                    mem_err  = 1'b1;                // second beat of the chosen burst
                    err_done = 1'b1;
                end else if (($random(seed) & 3) != 0) begin
                    mem_ready = 1'b1;               // otherwise a gap cycle
                end
            end
        end
    end

endmodule

// ==== rtl/icache_top.sv ====
`timescale 1ns/1ps

module icache_top (
    input  logic                 clock,
    input  logic                 reset,

    // fetch side
    input  icache_pkg::addr_t    fetch_addr,
    input  logic                 fetch_valid,
    output logic                 fetch_ready,
    output icache_pkg::word_t    fetch_data,

    // burst memory side
    output logic                 mem_valid,
    output icache_pkg::addr_t    mem_addr,
    input  logic                 mem_ready,
    input  icache_pkg::word_t    mem_data,
    input  logic                 mem_err
);

    logic               hit;
    logic               tag_write;
    icache_pkg::index_t tag_index;
    icache_pkg::tag_t   tag_value;
    logic               read_enable;
    icache_pkg::word_t  read_data;
    logic               refill_active;
    logic               refill_abort;

    fill_if fill_bus ();

    // ------------------------------
    // control
    // ------------------------------
    icache_ctrl u_ctrl (
        .clock         (clock),
        .reset         (reset),
        .fetch_addr    (fetch_addr),
        .fetch_valid   (fetch_valid),
        .hit           (hit),
        .mem_err       (mem_err),
        .fill          (fill_bus.monitor),
        .tag_write     (tag_write),
        .tag_index     (tag_index),
        .tag_value     (tag_value),
        .read_enable   (read_enable),
        .refill_active (refill_active),
        .refill_abort  (refill_abort),
        .mem_addr      (mem_addr),
        .fetch_ready   (fetch_ready)
    );

    refill_counter u_refill_counter (
        .clock         (clock),
        .reset         (reset),
        .refill_active (refill_active),
        .refill_abort  (refill_abort),
        .mem_ready     (mem_ready),
        .mem_data      (mem_data),
        .refill_index  (tag_index),     // line under refill
        .fill          (fill_bus.source)
    );

    // ------------------------------
    // storage
    // ------------------------------
    icache_tag_array u_tag_array (
        .clock       (clock),
        .reset       (reset),
        .lookup_addr (fetch_addr),
        .tag_write   (tag_write),
        .tag_index   (tag_index),
        .tag_value   (tag_value),
        .hit         (hit)
    );

    icache_data_array u_data_array (
        .clock       (clock),
        .fill        (fill_bus.sink),
        .read_enable (read_enable),
        .read_addr   (fetch_addr),
        .read_data   (read_data)
    );

    assign fetch_data = read_data;
    assign mem_valid  = refill_active;  // high for the whole burst

endmodule

// ==== rtl/icache_data_array.sv ====
`timescale 1ns/1ps
`include "icache_params.svh"

module icache_data_array (
    input  logic                 clock,
    fill_if.sink                 fill,
    input  logic                 read_enable,
    input  icache_pkg::addr_t    read_addr,
    output icache_pkg::word_t    read_data
);

    localparam int lines = 1 << `ICACHE_INDEX_BITS;
    localparam int words = `ICACHE_WORDS_PER_LINE;

    icache_pkg::word_t     storage [lines][words];

    icache_pkg::index_t    read_index;
    icache_pkg::word_sel_t read_sel;

    // ------------------------------
    // read address decode
    // ------------------------------
    assign read_index = read_addr[`ICACHE_OFFSET_BITS +: `ICACHE_INDEX_BITS];
    // mask keeps the select at zero for one-word lines
    assign read_sel   = icache_pkg::word_sel_t'((read_addr >> 2) & (words - 1));

    // one word per accepted beat
    always_ff @(posedge clock) begin
        if (fill.write) begin
            storage[fill.index][fill.word_sel] <= fill.data;
        end
    end

    // registered read, holds between lookups
    always_ff @(posedge clock) begin
        if (read_enable) begin
            read_data <= storage[read_index][read_sel];
        end
    end

endmodule

// ==== rtl/icache_tag_array.sv ====
`timescale 1ns/1ps
`include "icache_params.svh"

module icache_tag_array (
    input  logic                 clock,
    input  logic                 reset,
    input  icache_pkg::addr_t    lookup_addr,
    input  logic                 tag_write,
    input  icache_pkg::index_t   tag_index,
    input  icache_pkg::tag_t     tag_value,
    output logic                 hit
);

    localparam int lines    = 1 << `ICACHE_INDEX_BITS;
    localparam int tag_bits = $bits(icache_pkg::tag_t);

    icache_pkg::tag_t   tags [lines];
    logic [lines-1:0]   valid;

    icache_pkg::index_t lookup_index;
    icache_pkg::tag_t   lookup_tag;

    // ------------------------------
    // address split
    // ------------------------------
    assign lookup_index = lookup_addr[`ICACHE_OFFSET_BITS +: `ICACHE_INDEX_BITS];
    assign lookup_tag   = lookup_addr[31 -: tag_bits];

    // tag storage
    always_ff @(posedge clock) begin
        if (tag_write) begin
            tags[tag_index] <= tag_value;
        end
    end

    // valid bits, all lines empty out of reset
    always_ff @(posedge clock) begin
        if (reset) begin
            valid <= '0;
        end else if (tag_write) begin
            valid[tag_index] <= 1'b1;
        end
    end

    // direct mapped, single compare
    assign hit = valid[lookup_index] && (tags[lookup_index] == lookup_tag);

endmodule

// ==== rtl/refill_counter.sv ====
`timescale 1ns/1ps
`include "icache_params.svh"

module refill_counter (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 refill_active,
    input  logic                 refill_abort,
    input  logic                 mem_ready,
    input  icache_pkg::word_t    mem_data,
    input  icache_pkg::index_t   refill_index,
    fill_if.source               fill
);

    // count value of the final beat in a line
    localparam icache_pkg::beat_count_t last_count =
        icache_pkg::beat_count_t'(`ICACHE_WORDS_PER_LINE - 1);

    icache_pkg::beat_count_t count;
    logic                    accept;
    logic                    last_beat;

    // an error in the same cycle wins over a beat
    assign accept    = refill_active && mem_ready && !refill_abort;
    assign last_beat = accept && (count == last_count);

    // ------------------------------
    // beat counter
    // ------------------------------
    always_ff @(posedge clock) begin
        if (reset) begin
            count <= '0;
        end else if (refill_abort || last_beat) begin
            count <= '0;                // ready for the next burst
        end else if (accept) begin
            count <= count + 1'b1;
        end
    end

    assign fill.write    = accept;
    assign fill.index    = refill_index;
    assign fill.word_sel = icache_pkg::word_sel_t'(count);  // beats come in word order
    assign fill.data     = mem_data;
    assign fill.last     = last_beat;

endmodule

// ==== rtl/icache_ctrl.sv ====
`timescale 1ns/1ps
`include "icache_params.svh"

module icache_ctrl (
    input  logic                  clock,
    input  logic                  reset,
    input  icache_pkg::addr_t     fetch_addr,
    input  logic                  fetch_valid,
    input  logic                  hit,
    input  logic                  mem_err,
    fill_if.monitor               fill,
    output logic                  tag_write,
    output icache_pkg::index_t    tag_index,
    output icache_pkg::tag_t      tag_value,
    output logic                  read_enable,
    output logic                  refill_active,
    output logic                  refill_abort,
    output icache_pkg::addr_t     mem_addr,
    output logic                  fetch_ready
);

    localparam int off_bits = `ICACHE_OFFSET_BITS;
    localparam int tag_bits = $bits(icache_pkg::tag_t);

    icache_pkg::ctrl_state_t state_q;
    icache_pkg::ctrl_state_t state_d;

    icache_pkg::addr_t line_addr;   // fetch address, offset cleared
    logic              miss;
    logic              fill_last;

    assign line_addr = {fetch_addr[31:off_bits], {off_bits{1'b0}}};
    assign miss      = (state_q == icache_pkg::IDLE) && fetch_valid && !hit;
    assign fill_last = fill.write && fill.last;

    // ------------------------------
    // state register
    // ------------------------------
    always_ff @(posedge clock) begin
        if (reset) begin
            state_q <= icache_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // refill line address, held for the whole burst
    always_ff @(posedge clock) begin
        if (miss) begin
            mem_addr <= line_addr;
        end
    end

    // the latched line address also names the tag slot to fill
    assign tag_index = mem_addr[off_bits +: $bits(icache_pkg::index_t)];
    assign tag_value = mem_addr[31 -: tag_bits];

    // ------------------------------
    // next state and outputs
    // ------------------------------
    always_comb begin
        state_d      = state_q;
        read_enable  = 1'b0;
        tag_write    = 1'b0;
        refill_abort = 1'b0;

        case (state_q)
            icache_pkg::IDLE: begin
                if (fetch_valid) begin
                    if (hit) begin
                        read_enable = 1'b1;     // word lands in read_data at this edge
                        state_d     = icache_pkg::RESPOND;
                    end else begin
                        state_d = icache_pkg::REFILL;
                    end
                end
            end

            icache_pkg::REFILL: begin
                if (mem_err) begin
                    // line stays invalid, a held request simply misses again
                    refill_abort = 1'b1;
                    state_d      = icache_pkg::IDLE;
                end else if (fill_last) begin
                    tag_write = 1'b1;
                    state_d   = icache_pkg::FILL_DONE;
                end
            end

            icache_pkg::FILL_DONE: begin
                read_enable = 1'b1;             // line is valid now
                state_d     = icache_pkg::RESPOND;
            end

            icache_pkg::RESPOND: begin
                state_d = icache_pkg::IDLE;
            end

            default: begin
                state_d = icache_pkg::IDLE;
            end
        endcase
    end

    assign refill_active = (state_q == icache_pkg::REFILL);  // mem_valid
    assign fetch_ready   = (state_q == icache_pkg::RESPOND);

endmodule

// ==== rtl/fill_if.sv ====
`timescale 1ns/1ps

// one refill beat on its way into the line storage
interface fill_if;

    logic                  write;     // beat accepted this cycle
    icache_pkg::index_t    index;     // line being refilled
    icache_pkg::word_sel_t word_sel;  // word slot of this beat
    icache_pkg::word_t     data;
    logic                  last;      // final beat of the line

    // beat counter side
    modport source (
        output write, index, word_sel, data, last
    );

    // data array only needs the write itself
    modport sink (
        input write, index, word_sel, data
    );

    modport monitor (
        input write, last
    );

endinterface

// ==== rtl/icache_pkg.sv ====
`include "icache_params.svh"

package icache_pkg;

    // ------------------------------
    // derived widths
    // ------------------------------
    localparam int tag_bits  = 32 - `ICACHE_INDEX_BITS - `ICACHE_OFFSET_BITS;
    localparam int word_bits = `ICACHE_OFFSET_BITS - 2;   // word bits of the offset
    // one-word lines still get a 1-bit select
    localparam int sel_bits  = (word_bits > 0) ? word_bits : 1;

    typedef logic [31:0]                    addr_t;       // byte address
    typedef logic [31:0]                    word_t;       // instruction word
    typedef logic [tag_bits-1:0]            tag_t;
    typedef logic [`ICACHE_INDEX_BITS-1:0]  index_t;
    typedef logic [sel_bits-1:0]            word_sel_t;
    typedef logic [sel_bits:0]              beat_count_t; // one spare bit over word_sel_t

    // controller states
    typedef enum logic [1:0] {
        IDLE,       // lookup
        REFILL,     // burst in flight
        FILL_DONE,  // line written, read it back
        RESPOND     // fetch_ready pulse
    } ctrl_state_t;

endpackage

// ==== rtl/icache_params.svh ====
`ifndef ICACHE_PARAMS_SVH
`define ICACHE_PARAMS_SVH

// ------------------------------
// cache geometry
// ------------------------------

// line index width, 2**4 = 16 lines
`define ICACHE_INDEX_BITS 4

// byte offset inside a line, 2**3 = 8 bytes
`define ICACHE_OFFSET_BITS 3

// 32-bit words per line, also the refill burst length
`define ICACHE_WORDS_PER_LINE (1 << (`ICACHE_OFFSET_BITS - 2))

`endif
